// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_rv_pipe
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
+incdir+include
verilog/rv_pipe_pkg.sv
verilog/decode_stage.sv
verilog/id_exe_reg.sv
verilog/execute_stage.sv
verilog/rv_pipe_top.sv
testbench/tb_rv_pipe.sv

// File: include/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [31:0] model_regs [32];

function automatic logic [31:0] alu_model(input rv_pipe_pkg::alu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    case (op)
        rv_pipe_pkg::alu_sub:    return a - b;
        rv_pipe_pkg::alu_and:    return a & b;
        rv_pipe_pkg::alu_or:     return a | b;
        rv_pipe_pkg::alu_xor:    return a ^ b;
        rv_pipe_pkg::alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_pipe_pkg::alu_sll:    return a << b[4:0];
        rv_pipe_pkg::alu_srl:    return a >> b[4:0];
        rv_pipe_pkg::alu_pass_b: return b;
        default:                 return a + b;
    endcase
endfunction

// architectural execution of one instruction against the model register file.
function automatic void model_execute(input logic [31:0] word, input logic [31:0] at_pc,
                                      output bit ok, output bit wr, output logic [31:0] value,
                                      output bit taken, output logic [31:0] target);
    logic [31:0]          a;
    logic [31:0]          b;
    logic [2:0]           f3;
    rv_pipe_pkg::alu_op_e aop;
    a      = (word[19:15] == 5'd0) ? 32'd0 : model_regs[word[19:15]];
    b      = (word[24:20] == 5'd0) ? 32'd0 : model_regs[word[24:20]];
    f3     = word[14:12];
    ok     = 1'b1;
    wr     = 1'b0;
    taken  = 1'b0;
    value  = 32'd0;
    target = 32'd0;
    aop    = rv_pipe_pkg::alu_add;
    case (word[6:0])
        rv_pipe_pkg::op_reg: begin
            wr = 1'b1;
            case ({word[31:25], f3})
                {7'h00, 3'b000}: aop = rv_pipe_pkg::alu_add;
                {7'h20, 3'b000}: aop = rv_pipe_pkg::alu_sub;
                {7'h00, 3'b111}: aop = rv_pipe_pkg::alu_and;
                {7'h00, 3'b110}: aop = rv_pipe_pkg::alu_or;
                {7'h00, 3'b100}: aop = rv_pipe_pkg::alu_xor;
                {7'h00, 3'b010}: aop = rv_pipe_pkg::alu_slt;
                {7'h00, 3'b001}: aop = rv_pipe_pkg::alu_sll;
                {7'h00, 3'b101}: aop = rv_pipe_pkg::alu_srl;
                default:         ok  = 1'b0;
            endcase
            value = alu_model(aop, a, b);
        end
        rv_pipe_pkg::op_imm: begin
            wr = 1'b1;
            case (f3)
                3'b000:  aop = rv_pipe_pkg::alu_add;
                3'b111:  aop = rv_pipe_pkg::alu_and;
                3'b110:  aop = rv_pipe_pkg::alu_or;
                3'b100:  aop = rv_pipe_pkg::alu_xor;
                3'b010:  aop = rv_pipe_pkg::alu_slt;
                default: ok  = 1'b0;
            endcase
            value = alu_model(aop, a, {{20{word[31]}}, word[31:20]});
        end
        rv_pipe_pkg::op_lui: begin
            wr    = 1'b1;
            value = {word[31:12], 12'b0};
        end
        rv_pipe_pkg::op_branch: begin
            ok     = (f3 == 3'b000) || (f3 == 3'b001);
            taken  = f3[0] ? (a != b) : (a == b);
            target = at_pc + {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            value  = a - b;
        end
        rv_pipe_pkg::op_jal: begin
            wr     = 1'b1;
            taken  = 1'b1;
            value  = at_pc + 32'd4;
            target = at_pc + {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        wr    = 1'b0;
        taken = 1'b0;
    end
    wr = wr && (word[11:7] != 5'd0);
    if (wr) begin
        model_regs[word[11:7]] = value;
    end
endfunction

`endif

// File: testbench/tb_rv_pipe.sv
`timescale 1ns/1ps

module tb_rv_pipe;

    localparam int count_width = 64;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic        retire_reg_write;
    logic [count_width-1:0] cycle_count;
    logic [count_width-1:0] instret_count;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];
    bit          exp_write [$];
    logic [count_width-1:0] exp_edge [$];
    logic [count_width-1:0] expected_retires;
    logic [count_width-1:0] edge_count;
    logic [31:0] next_pc;
    bit          prev_taken;
    logic [31:0] prev_target;
    bit          squash_next;

    `include "tb_rv_model.svh"

    rv_pipe_top #(.count_width(count_width)) u_rv_pipe_top (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_value(retire_value), .retire_reg_write(retire_reg_write),
        .cycle_count(cycle_count), .instret_count(instret_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) abort_run($sformatf("** Error at %0t: %s = %h, expected %h",
                                             $time, name, act, exp));
    endtask

    task automatic check_reg(input string name, input logic [4:0] act, input logic [4:0] exp);
        if (act !== exp) abort_run($sformatf("** Error at %0t: %s = %0d, expected %0d",
                                             $time, name, act, exp));
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) abort_run($sformatf("** Error at %0t: %s = %b, expected %b",
                                             $time, name, act, exp));
    endtask

    task automatic check_count(input string name, input logic [count_width-1:0] act,
                               input logic [count_width-1:0] exp);
        if (act !== exp) abort_run($sformatf("** Error at %0t: %s = %0d, expected %0d",
                                             $time, name, act, exp));
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pipe_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pipe_pkg::op_imm};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pipe_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pipe_pkg::op_jal};
    endfunction

    // mask limits the registers so that neighbouring instructions depend on each other.
    function automatic logic [31:0] random_alu_instr(input logic [4:0] mask);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $urandom();
        s  = $urandom();
        f7 = 7'h00;
        f3 = r[18:16];
        if (r[15]) begin
            if (f3 == 3'b011) f3 = 3'b000;
            if (f3 == 3'b000 && r[19]) f7 = 7'h20;
            return enc_r(f7, r[14:10] & mask, r[9:5] & mask, f3, r[4:0] & mask);
        end
        if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) f3 = 3'b000;
        return enc_i(s[11:0], r[9:5] & mask, f3, r[4:0] & mask);
    endfunction

    task automatic send(input logic valid, input logic [31:0] word);
        bit          ok;
        bit          wr;
        bit          taken;
        logic [31:0] value;
        logic [31:0] target;
        @(negedge clk);
        check_bit("redirect_valid", redirect_valid, prev_taken);
        if (prev_taken) check_word("redirect_pc", redirect_pc, prev_target);
        instr_valid = valid;
        instr       = word;
        pc          = next_pc;
        prev_taken  = 1'b0;
        if (squash_next) begin
            squash_next = 1'b0; // this slot is flushed at the next edge.
        end else if (valid) begin
            model_execute(word, next_pc, ok, wr, value, taken, target);
            if (ok) begin
                exp_pc.push_back(next_pc);
                exp_rd.push_back(word[11:7]);
                exp_value.push_back(value);
                exp_write.push_back(wr);
                exp_edge.push_back(edge_count + 64'd2); // retires two edges after issue.
                expected_retires = expected_retires + 64'd1;
                prev_taken  = taken;
                prev_target = target;
                squash_next = taken;
            end
        end
        next_pc = next_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (!reset) edge_count <= edge_count + 64'd1;
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_count("cycle_count", cycle_count, edge_count);
            if (retire_valid) begin
                if (exp_pc.size() == 0) begin
                    abort_run("an instruction retired that was not expected");
                end else begin
                    check_count("retire_edge", edge_count, exp_edge.pop_front());
                    check_word("retire_pc", retire_pc, exp_pc.pop_front());
                    check_reg("retire_rd", retire_rd, exp_rd.pop_front());
                    check_bit("retire_reg_write", retire_reg_write, exp_write[0]);
                    if (exp_write.pop_front()) begin
                        check_word("retire_value", retire_value, exp_value.pop_front());
                    end else begin
                        void'(exp_value.pop_front());
                    end
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        void'($urandom(91));
        reset            = 1'b1;
        instr_valid      = 1'b0;
        instr            = 32'd0;
        pc               = 32'd0;
        next_pc          = 32'h0000_1000;
        prev_taken       = 1'b0;
        prev_target      = 32'd0;
        squash_next      = 1'b0;
        expected_retires = '0;
        edge_count       = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_count("cycle_count", cycle_count, '0);
        check_count("instret_count", instret_count, '0);

        for (int i = 0; i < 40; i++) begin
            send(1'b1, random_alu_instr(5'h1f));
            send(1'b0, $urandom());
        end
        send(1'b1, enc_i(12'd77, 5'd0, 3'b000, 5'd5));
        send(1'b1, enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
        send(1'b1, enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));
        send(1'b1, enc_i(12'd3, 5'd5, 3'b000, 5'd0));
        send(1'b1, enc_r(7'h00, 5'd7, 5'd0, 3'b000, 5'd8));
        send(1'b1, {20'habcde, 5'd9, rv_pipe_pkg::op_lui});
        send(1'b1, enc_r(7'h00, 5'd5, 5'd9, 3'b101, 5'd9));
        for (int i = 0; i < 60; i++) begin
            send(1'b1, random_alu_instr(5'h03));
        end

        send(1'b1, enc_i(12'd5, 5'd0, 3'b000, 5'd1));
        send(1'b1, enc_i(12'd5, 5'd0, 3'b000, 5'd2));
        send(1'b1, enc_i(12'd7, 5'd0, 3'b000, 5'd3));
        send(1'b1, enc_b(13'd16, 5'd2, 5'd1, 3'b000));
        send(1'b1, enc_i(12'd99, 5'd0, 3'b000, 5'd9));
        send(1'b1, enc_b(13'd24, 5'd2, 5'd1, 3'b001));
        send(1'b1, enc_i(12'd11, 5'd0, 3'b000, 5'd9));
        send(1'b1, enc_b(13'h1ff0, 5'd3, 5'd1, 3'b001));
        send(1'b1, enc_i(12'd12, 5'd0, 3'b000, 5'd9));
        send(1'b1, enc_j(21'h1ffff8, 5'd10));
        send(1'b1, enc_r(7'h00, 5'd10, 5'd10, 3'b000, 5'd11));
        send(1'b1, enc_j(21'd12, 5'd0));
        send(1'b0, 32'd0);
        send(1'b1, enc_r(7'h00, 5'd10, 5'd10, 3'b000, 5'd11));
        for (int i = 0; i < 40; i++) begin
            send(1'b1, enc_b({12'($urandom_range(4095, 0)), 1'b0},
                             5'd1 + 5'($urandom_range(2, 0)),
                             5'd1 + 5'($urandom_range(2, 0)), 3'($urandom_range(1, 0))));
            send(1'b1, random_alu_instr(5'h03));
        end

        send(1'b1, 32'h0000_007f);
        send(1'b1, enc_i(12'd1, 5'd1, 3'b001, 5'd4));
        send(1'b1, enc_r(7'h01, 5'd1, 5'd1, 3'b000, 5'd4));
        send(1'b1, enc_b(13'd8, 5'd1, 5'd1, 3'b100));
        send(1'b0, enc_i(12'd1, 5'd0, 3'b000, 5'd4));
        repeat (4) send(1'b0, 32'd0);

        wait_cycles = 0;
        while (exp_pc.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_pc.size() != 0) begin
            abort_run("expected retires did not drain before the timeout");
        end else begin
            @(negedge clk);
            check_count("instret_count", instret_count, expected_retires);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      instr_valid,
    input  logic [31:0]                               instr,
    input  logic [rv_pipe_pkg::xlen-1:0]              pc,
    input  logic                                      wb_en,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    wb_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]              wb_data,
    output logic                                      id_valid,
    output logic [rv_pipe_pkg::xlen-1:0]              id_pc,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    rs1_addr,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    rs2_addr,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    rd_addr,
    output logic [rv_pipe_pkg::xlen-1:0]              rs1_data,
    output logic [rv_pipe_pkg::xlen-1:0]              rs2_data,
    output logic [rv_pipe_pkg::xlen-1:0]              imm,
    output rv_pipe_pkg::alu_op_e                      alu_op,
    output logic                                      alu_src_imm,
    output rv_pipe_pkg::branch_e                      branch_kind,
    output logic                                      reg_write
);

    logic [rv_pipe_pkg::xlen-1:0] regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       known;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign id_pc    = pc;
    assign id_valid = instr_valid && known;

    always_comb begin
        known       = 1'b0;
        alu_op      = rv_pipe_pkg::alu_add;
        alu_src_imm = 1'b0;
        branch_kind = rv_pipe_pkg::br_none;
        reg_write   = 1'b0;
        imm         = '0;
        case (opcode)
            rv_pipe_pkg::op_reg: begin
                known     = 1'b1;
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = rv_pipe_pkg::alu_add;
                    {7'h20, 3'b000}: alu_op = rv_pipe_pkg::alu_sub;
                    {7'h00, 3'b111}: alu_op = rv_pipe_pkg::alu_and;
                    {7'h00, 3'b110}: alu_op = rv_pipe_pkg::alu_or;
                    {7'h00, 3'b100}: alu_op = rv_pipe_pkg::alu_xor;
                    {7'h00, 3'b010}: alu_op = rv_pipe_pkg::alu_slt;
                    {7'h00, 3'b001}: alu_op = rv_pipe_pkg::alu_sll;
                    {7'h00, 3'b101}: alu_op = rv_pipe_pkg::alu_srl;
                    default:         known  = 1'b0;
                endcase
            end
            rv_pipe_pkg::op_imm: begin
                known       = 1'b1;
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'b000:  alu_op = rv_pipe_pkg::alu_add;
                    3'b111:  alu_op = rv_pipe_pkg::alu_and;
                    3'b110:  alu_op = rv_pipe_pkg::alu_or;
                    3'b100:  alu_op = rv_pipe_pkg::alu_xor;
                    3'b010:  alu_op = rv_pipe_pkg::alu_slt;
                    default: known  = 1'b0;
                endcase
            end
            rv_pipe_pkg::op_lui: begin
                known       = 1'b1;
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = rv_pipe_pkg::alu_pass_b;
                imm         = {instr[31:12], 12'b0};
            end
            rv_pipe_pkg::op_branch: begin
                known  = (funct3 == 3'b000) || (funct3 == 3'b001);
                alu_op = rv_pipe_pkg::alu_sub; // the retire value is rs1 minus rs2.
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
                branch_kind = funct3[0] ? rv_pipe_pkg::br_ne : rv_pipe_pkg::br_eq;
            end
            rv_pipe_pkg::op_jal: begin
                known       = 1'b1;
                reg_write   = 1'b1;
                branch_kind = rv_pipe_pkg::br_jal;
                imm         = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            end
            default: known = 1'b0;
        endcase
        if (!(instr_valid && known)) begin
            alu_op      = rv_pipe_pkg::alu_add;
            alu_src_imm = 1'b0;
            branch_kind = rv_pipe_pkg::br_none;
            reg_write   = 1'b0;
            imm         = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // a write landing this cycle is visible to the read in the same cycle.
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb_en && wb_addr == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb_en && wb_addr == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int count_width = 64
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      ex_valid,
    input  logic [rv_pipe_pkg::xlen-1:0]              ex_pc,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rs1_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rs2_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rd_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]              ex_rs1_data,
    input  logic [rv_pipe_pkg::xlen-1:0]              ex_rs2_data,
    input  logic [rv_pipe_pkg::xlen-1:0]              ex_imm,
    input  rv_pipe_pkg::alu_op_e                      ex_alu_op,
    input  logic                                      ex_alu_src_imm,
    input  rv_pipe_pkg::branch_e                      ex_branch_kind,
    input  logic                                      ex_reg_write,
    output logic                                      flush,
    output logic [rv_pipe_pkg::xlen-1:0]              redirect_pc,
    output logic                                      wb_en,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    wb_addr,
    output logic [rv_pipe_pkg::xlen-1:0]              wb_data,
    output logic                                      retire_valid,
    output logic [rv_pipe_pkg::xlen-1:0]              retire_pc,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    retire_rd,
    output logic [rv_pipe_pkg::xlen-1:0]              retire_value,
    output logic                                      retire_reg_write,
    output logic [count_width-1:0]                    cycle_count,
    output logic [count_width-1:0]                    instret_count
);

    logic                         fwd_a;
    logic                         fwd_b;
    logic [rv_pipe_pkg::xlen-1:0] op_a;
    logic [rv_pipe_pkg::xlen-1:0] op_b_reg;
    logic [rv_pipe_pkg::xlen-1:0] op_b;
    logic [rv_pipe_pkg::xlen-1:0] alu_result;
    logic [rv_pipe_pkg::xlen-1:0] result;
    logic                         equal;

    // older results reach EX through the register file and its bypass.
    assign fwd_a = retire_valid && retire_reg_write && retire_rd != '0 &&
                   retire_rd == ex_rs1_addr;
    assign fwd_b = retire_valid && retire_reg_write && retire_rd != '0 &&
                   retire_rd == ex_rs2_addr;

    assign op_a     = fwd_a ? retire_value : ex_rs1_data;
    assign op_b_reg = fwd_b ? retire_value : ex_rs2_data;
    assign op_b     = ex_alu_src_imm ? ex_imm : op_b_reg;

    always_comb begin
        case (ex_alu_op)
            rv_pipe_pkg::alu_add:    alu_result = op_a + op_b;
            rv_pipe_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_pipe_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pipe_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pipe_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pipe_pkg::alu_slt:    alu_result = {{(rv_pipe_pkg::xlen-1){1'b0}},
                                                   $signed(op_a) < $signed(op_b)};
            rv_pipe_pkg::alu_sll:    alu_result = op_a << op_b[4:0];
            rv_pipe_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
            rv_pipe_pkg::alu_pass_b: alu_result = op_b;
            default:                 alu_result = '0;
        endcase
    end

    assign equal = (op_a == op_b_reg);
    assign flush = ex_valid && ((ex_branch_kind == rv_pipe_pkg::br_jal) ||
                                (ex_branch_kind == rv_pipe_pkg::br_eq && equal) ||
                                (ex_branch_kind == rv_pipe_pkg::br_ne && !equal));
    assign redirect_pc = ex_pc + ex_imm;
    assign result = (ex_branch_kind == rv_pipe_pkg::br_jal) ? ex_pc + 32'd4 : alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid     <= 1'b0;
            retire_reg_write <= 1'b0;
            cycle_count      <= '0;
            instret_count    <= '0;
        end else begin
            retire_valid     <= ex_valid;
            retire_reg_write <= ex_valid && ex_reg_write && ex_rd_addr != '0; // x0 is never written.
            cycle_count      <= cycle_count + count_width'(1);
            if (ex_valid) begin
                instret_count <= instret_count + count_width'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        retire_pc    <= ex_pc;
        retire_rd    <= ex_rd_addr;
        retire_value <= result;
    end

    assign wb_en   = retire_valid && retire_reg_write;
    assign wb_addr = retire_rd;
    assign wb_data = retire_value;

endmodule

// File: verilog/id_exe_reg.sv
`timescale 1ns/1ps

module id_exe_reg (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush,
    input  logic                                      id_valid,
    input  logic [rv_pipe_pkg::xlen-1:0]              id_pc,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    rs1_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    rs2_addr,
    input  logic [rv_pipe_pkg::reg_addr_width-1:0]    rd_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]              rs1_data,
    input  logic [rv_pipe_pkg::xlen-1:0]              rs2_data,
    input  logic [rv_pipe_pkg::xlen-1:0]              imm,
    input  rv_pipe_pkg::alu_op_e                      alu_op,
    input  logic                                      alu_src_imm,
    input  rv_pipe_pkg::branch_e                      branch_kind,
    input  logic                                      reg_write,
    output logic                                      ex_valid,
    output logic [rv_pipe_pkg::xlen-1:0]              ex_pc,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rs1_addr,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rs2_addr,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    ex_rd_addr,
    output logic [rv_pipe_pkg::xlen-1:0]              ex_rs1_data,
    output logic [rv_pipe_pkg::xlen-1:0]              ex_rs2_data,
    output logic [rv_pipe_pkg::xlen-1:0]              ex_imm,
    output rv_pipe_pkg::alu_op_e                      ex_alu_op,
    output logic                                      ex_alu_src_imm,
    output rv_pipe_pkg::branch_e                      ex_branch_kind,
    output logic                                      ex_reg_write
);

    logic load;

    assign load = id_valid && !flush; // a squashed or empty slot becomes an all-zero bubble.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid       <= 1'b0;
            ex_pc          <= '0;
            ex_rs1_addr    <= '0;
            ex_rs2_addr    <= '0;
            ex_rd_addr     <= '0;
            ex_rs1_data    <= '0;
            ex_rs2_data    <= '0;
            ex_imm         <= '0;
            ex_alu_op      <= rv_pipe_pkg::alu_add;
            ex_alu_src_imm <= 1'b0;
            ex_branch_kind <= rv_pipe_pkg::br_none;
            ex_reg_write   <= 1'b0;
        end else begin
            ex_valid       <= load;
            ex_pc          <= load ? id_pc : '0;
            ex_rs1_addr    <= load ? rs1_addr : '0;
            ex_rs2_addr    <= load ? rs2_addr : '0;
            ex_rd_addr     <= load ? rd_addr : '0;
            ex_rs1_data    <= load ? rs1_data : '0;
            ex_rs2_data    <= load ? rs2_data : '0;
            ex_imm         <= load ? imm : '0;
            ex_alu_op      <= load ? alu_op : rv_pipe_pkg::alu_add;
            ex_alu_src_imm <= load && alu_src_imm;
            ex_branch_kind <= load ? branch_kind : rv_pipe_pkg::br_none;
            ex_reg_write   <= load && reg_write;
        end
    end

endmodule

// File: verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    // rv32i major opcodes handled by this slice.
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0, // zero so that a bubble decodes as add.
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8  // operand b goes straight to the result, used by lui.
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_eq   = 2'd1,
        br_ne   = 2'd2,
        br_jal  = 2'd3
    } branch_e;

endpackage

// File: verilog/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter int count_width = 64
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      instr_valid,
    input  logic [31:0]                               instr,
    input  logic [rv_pipe_pkg::xlen-1:0]              pc,
    output logic                                      redirect_valid,
    output logic [rv_pipe_pkg::xlen-1:0]              redirect_pc,
    output logic                                      retire_valid,
    output logic [rv_pipe_pkg::xlen-1:0]              retire_pc,
    output logic [rv_pipe_pkg::reg_addr_width-1:0]    retire_rd,
    output logic [rv_pipe_pkg::xlen-1:0]              retire_value,
    output logic                                      retire_reg_write,
    output logic [count_width-1:0]                    cycle_count,
    output logic [count_width-1:0]                    instret_count
);

    logic                                   id_valid, ex_valid;
    logic [rv_pipe_pkg::xlen-1:0]           id_pc, ex_pc;
    logic [rv_pipe_pkg::reg_addr_width-1:0] id_rs1_addr, ex_rs1_addr;
    logic [rv_pipe_pkg::reg_addr_width-1:0] id_rs2_addr, ex_rs2_addr;
    logic [rv_pipe_pkg::reg_addr_width-1:0] id_rd_addr, ex_rd_addr;
    logic [rv_pipe_pkg::xlen-1:0]           id_rs1_data, ex_rs1_data;
    logic [rv_pipe_pkg::xlen-1:0]           id_rs2_data, ex_rs2_data;
    logic [rv_pipe_pkg::xlen-1:0]           id_imm, ex_imm;
    rv_pipe_pkg::alu_op_e                   id_alu_op, ex_alu_op;
    logic                                   id_alu_src_imm, ex_alu_src_imm;
    rv_pipe_pkg::branch_e                   id_branch_kind, ex_branch_kind;
    logic                                   id_reg_write, ex_reg_write;
    logic                                   wb_en;
    logic [rv_pipe_pkg::reg_addr_width-1:0] wb_addr;
    logic [rv_pipe_pkg::xlen-1:0]           wb_data;

    decode_stage u_decode_stage (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .id_valid(id_valid), .id_pc(id_pc),
        .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr), .rd_addr(id_rd_addr),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data), .imm(id_imm),
        .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm),
        .branch_kind(id_branch_kind), .reg_write(id_reg_write)
    );

    // the redirect output doubles as the flush into the ID/EX register.
    id_exe_reg u_id_exe_reg (
        .clk(clk), .reset(reset), .flush(redirect_valid),
        .id_valid(id_valid), .id_pc(id_pc),
        .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr), .rd_addr(id_rd_addr),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data), .imm(id_imm),
        .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm),
        .branch_kind(id_branch_kind), .reg_write(id_reg_write),
        .ex_valid(ex_valid), .ex_pc(ex_pc),
        .ex_rs1_addr(ex_rs1_addr), .ex_rs2_addr(ex_rs2_addr), .ex_rd_addr(ex_rd_addr),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data), .ex_imm(ex_imm),
        .ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm),
        .ex_branch_kind(ex_branch_kind), .ex_reg_write(ex_reg_write)
    );

    execute_stage #(.count_width(count_width)) u_execute_stage (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_pc(ex_pc),
        .ex_rs1_addr(ex_rs1_addr), .ex_rs2_addr(ex_rs2_addr), .ex_rd_addr(ex_rd_addr),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data), .ex_imm(ex_imm),
        .ex_alu_op(ex_alu_op), .ex_alu_src_imm(ex_alu_src_imm),
        .ex_branch_kind(ex_branch_kind), .ex_reg_write(ex_reg_write),
        .flush(redirect_valid), .redirect_pc(redirect_pc),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_value(retire_value), .retire_reg_write(retire_reg_write),
        .cycle_count(cycle_count), .instret_count(instret_count)
    );

endmodule
